//--- sim.f
hw/core_isa_pkg.sv
hw/core_pipe_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/core_top.sv
sim/clk_gen.sv
sim/core_chk.sv
sim/core_tb.sv

//--- sim/core_tb.sv
module core_tb;

    typedef struct packed {
        core_isa_pkg::u32_t inst;
        logic [1:0]         gap;
    } stim_t;

    typedef struct packed {
        logic [63:0]            t;
        core_isa_pkg::u32_t     pc;
        core_isa_pkg::u32_t     inst;
        logic                   wen;
        core_isa_pkg::reg_idx_t wnum;
        core_isa_pkg::u32_t     wdata;
    } trace_t;

    typedef struct packed {
        logic [63:0]        t;
        core_isa_pkg::u32_t target;
    } redir_t;

    localparam int     TABLE_LEN   = 24;
    localparam int     RAND_LEN    = 16;
    localparam int     N_INST      = TABLE_LEN + RAND_LEN;
    localparam int     PERIOD      = 40;
    localparam int     WB_DELAY    = 3 * PERIOD; // Drive edge to the sample after wb.
    localparam int     REDIR_DELAY = 2 * PERIOD;
    localparam longint WATCHDOG    = (N_INST * 8 + 20) * PERIOD;

    logic                   clk, rst_n;
    logic                   inst_valid;
    core_isa_pkg::u32_t     inst, pc;
    logic                   redirect_valid;
    core_isa_pkg::u32_t     redirect_pc;
    logic                   wb_valid, wb_rf_wen;
    core_isa_pkg::u32_t     wb_pc, wb_inst, wb_rf_wdata;
    core_isa_pkg::reg_idx_t wb_rf_wnum;

    stim_t              stim [TABLE_LEN];
    core_isa_pkg::u32_t model_regs [core_isa_pkg::REG_NUM];
    trace_t             trace_q [$];
    redir_t             redir_q [$];
    logic [15:0]        lfsr;
    logic               squash_next;
    int                 errors, tests, passed, squashed;

    clk_gen u_clk (.clk, .rst_n);

    core_top dut (
        .clk, .rst_n,
        .inst_valid, .inst, .pc,
        .redirect_valid, .redirect_pc,
        .wb_valid, .wb_pc, .wb_inst,
        .wb_rf_wen, .wb_rf_wnum, .wb_rf_wdata
    );

    bind core_top core_chk u_chk (.*);

    function automatic core_isa_pkg::u32_t enc_i(
        input core_isa_pkg::opcode_t  op,
        input core_isa_pkg::reg_idx_t rd,
        input core_isa_pkg::reg_idx_t rj,
        input logic [15:0]            imm
    );
        return {op, rd, rj, imm};
    endfunction

    function automatic core_isa_pkg::u32_t enc_r(
        input core_isa_pkg::opcode_t  op,
        input core_isa_pkg::reg_idx_t rd,
        input core_isa_pkg::reg_idx_t rj,
        input core_isa_pkg::reg_idx_t rk
    );
        return enc_i(op, rd, rj, {rk, 11'b0});
    endfunction

    function automatic stim_t make_entry(input core_isa_pkg::u32_t w, input int gap);
        stim_t e;
        e.inst = w;
        e.gap  = 2'(gap);
        return e;
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic core_isa_pkg::u32_t random_inst();
        int                     sel;
        core_isa_pkg::reg_idx_t rd, rj, rk;
        sel = take_bits(3) % 5;
        rd  = core_isa_pkg::reg_idx_t'(take_bits(5));
        rj  = core_isa_pkg::reg_idx_t'(take_bits(5));
        rk  = core_isa_pkg::reg_idx_t'(take_bits(5));
        case (sel)
            0:       return enc_r(core_isa_pkg::OP_ADD, rd, rj, rk);
            1:       return enc_r(core_isa_pkg::OP_SUB, rd, rj, rk);
            2:       return enc_r(core_isa_pkg::OP_XOR, rd, rj, rk);
            3:       return enc_r(core_isa_pkg::OP_SLT, rd, rj, rk);
            default: return enc_i(core_isa_pkg::OP_ADDI, rd, rj, 16'(take_bits(16)));
        endcase
    endfunction

    task automatic fill_table();
        stim[0]  = make_entry(enc_i(core_isa_pkg::OP_ADDI, 1, 0, 16'd7), 2);
        stim[1]  = make_entry(enc_i(core_isa_pkg::OP_ADDI, 2, 0, 16'hfffd), 2);
        stim[2]  = make_entry(enc_r(core_isa_pkg::OP_ADD, 3, 1, 2), 0);
        stim[3]  = make_entry(enc_r(core_isa_pkg::OP_SUB, 4, 3, 1), 0); // From execute.
        stim[4]  = make_entry(enc_r(core_isa_pkg::OP_AND, 5, 4, 1), 1);
        stim[5]  = make_entry(enc_r(core_isa_pkg::OP_OR, 6, 5, 3), 2);  // From writeback.
        stim[6]  = make_entry(enc_r(core_isa_pkg::OP_XOR, 7, 6, 1), 0); // From the register file.
        stim[7]  = make_entry(enc_r(core_isa_pkg::OP_SLT, 8, 2, 1), 0);
        stim[8]  = make_entry(enc_r(core_isa_pkg::OP_SLT, 9, 1, 2), 1);
        stim[9]  = make_entry(enc_i(core_isa_pkg::OP_LUI, 10, 0, 16'h1234), 0);
        stim[10] = make_entry(enc_i(core_isa_pkg::OP_ADDI, 10, 10, 16'h5678), 0);
        stim[11] = make_entry(enc_r(core_isa_pkg::OP_ADD, 0, 1, 1), 0);
        stim[12] = make_entry(enc_r(6'h3f, 11, 1, 1), 1);                      // Unknown opcode.
        stim[13] = make_entry(enc_i(core_isa_pkg::OP_BEQ, 1, 1, 16'd8), 0);    // Taken.
        stim[14] = make_entry(enc_i(core_isa_pkg::OP_ADDI, 11, 0, 16'd99), 0); // Squashed.
        stim[15] = make_entry(enc_i(core_isa_pkg::OP_ADDI, 12, 0, 16'd7), 1);
        stim[16] = make_entry(enc_i(core_isa_pkg::OP_BNE, 2, 1, 16'hfffc), 1);
        stim[17] = make_entry(enc_i(core_isa_pkg::OP_ADDI, 13, 12, 16'd1), 0);
        stim[18] = make_entry(enc_i(core_isa_pkg::OP_BEQ, 2, 1, 16'd4), 0);    // Not taken.
        stim[19] = make_entry(enc_r(core_isa_pkg::OP_ADD, 14, 13, 12), 0);
        stim[20] = make_entry(enc_i(core_isa_pkg::OP_BNE, 14, 14, 16'd3), 0);
        stim[21] = make_entry(enc_r(core_isa_pkg::OP_SUB, 15, 14, 13), 2);
        stim[22] = make_entry(enc_i(core_isa_pkg::OP_BEQ, 15, 15, 16'd2), 0);
        stim[23] = make_entry(enc_i(core_isa_pkg::OP_BEQ, 16, 16, 16'd5), 2);  // Squashed branch.
    endtask

    task automatic model_issue(input core_isa_pkg::u32_t w, input core_isa_pkg::u32_t ipc,
                               input int gap);
        core_isa_pkg::opcode_t  op;
        core_isa_pkg::reg_idx_t rd, rj, rk;
        core_isa_pkg::u32_t     a, b, d, imm_s, res;
        logic                   wen, taken;
        trace_t                 rec;
        redir_t                 rr;
        op    = w[core_isa_pkg::OPC_LSB +: 6];
        rd    = w[core_isa_pkg::RD_LSB +: 5];
        rj    = w[core_isa_pkg::RJ_LSB +: 5];
        rk    = w[core_isa_pkg::RK_LSB +: 5];
        imm_s = {{16{w[15]}}, w[15:0]};
        a     = model_regs[rj];
        b     = model_regs[rk];
        d     = model_regs[rd];
        res   = '0;
        wen   = 1'b1;
        taken = 1'b0;
        if (squash_next) begin
            squash_next = 1'b0;
            squashed++;
            return;
        end
        case (op)
            core_isa_pkg::OP_ADD:  res = a + b;
            core_isa_pkg::OP_SUB:  res = a - b;
            core_isa_pkg::OP_AND:  res = a & b;
            core_isa_pkg::OP_OR:   res = a | b;
            core_isa_pkg::OP_XOR:  res = a ^ b;
            core_isa_pkg::OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            core_isa_pkg::OP_ADDI: res = a + imm_s;
            core_isa_pkg::OP_LUI:  res = {w[15:0], 16'h0000};
            core_isa_pkg::OP_BEQ: begin
                wen   = 1'b0;
                taken = (a == d);
            end
            core_isa_pkg::OP_BNE: begin
                wen   = 1'b0;
                taken = (a != d);
            end
            default: wen = 1'b0;
        endcase
        if (rd == '0) wen = 1'b0;
        if (wen) model_regs[rd] = res;
        rec.t     = $time + WB_DELAY;
        rec.pc    = ipc;
        rec.inst  = w;
        rec.wen   = wen;
        rec.wnum  = rd;
        rec.wdata = res;
        trace_q.push_back(rec);
        if (taken) begin
            rr.t      = $time + REDIR_DELAY;
            rr.target = ipc + imm_s * 4;
            redir_q.push_back(rr);
        end
        squash_next = taken && (gap == 0); // Next issue lands in decode during the redirect.
    endtask

    task automatic issue(input core_isa_pkg::u32_t w, input int gap);
        inst_valid = 1'b1;
        inst       = w;
        model_issue(w, pc, gap);
        @(negedge clk);
        inst_valid = 1'b0;
        pc         = pc + 4;
        repeat (gap) @(negedge clk);
    endtask

    always @(negedge clk) begin : monitor
        trace_t exp;
        redir_t rr;
        int     bad;
        if (redir_q.size() != 0 && redir_q[0].t < $time) begin
            rr = redir_q.pop_front();
            $display("missing redirect to %h, expected at %0t", rr.target, rr.t);
            errors++;
        end
        if (redirect_valid !== 1'b0) begin
            if (redir_q.size() == 0 || redir_q[0].t != $time) begin
                $display("unexpected redirect to %h at %0t", redirect_pc, $time);
                errors++;
            end else begin
                rr = redir_q.pop_front();
                if (redirect_pc !== rr.target) begin
                    $display("[FAIL] %0t redirect_pc got %h expected %h",
                             $time, redirect_pc, rr.target);
                    errors++;
                end
            end
        end
        if (trace_q.size() != 0 && trace_q[0].t < $time) begin
            exp = trace_q.pop_front();
            $display("instruction at pc %h never retired, expected at %0t", exp.pc, exp.t);
            errors++;
            tests++;
        end
        if (wb_valid !== 1'b0) begin
            if (trace_q.size() == 0) begin
                $display("unexpected retire of pc %h at %0t", wb_pc, $time);
                errors++;
            end else begin
                exp = trace_q.pop_front();
                bad = 0;
                if (exp.t != $time) begin
                    $display("pc %h retired at %0t, expected at %0t", exp.pc, $time, exp.t);
                    bad++;
                end
                if (wb_pc !== exp.pc) begin
                    $display("[FAIL] %0t wb_pc got %h expected %h", $time, wb_pc, exp.pc);
                    bad++;
                end
                if (wb_inst !== exp.inst) begin
                    $display("[FAIL] %0t wb_inst got %h expected %h", $time, wb_inst, exp.inst);
                    bad++;
                end
                if (wb_rf_wen !== exp.wen) begin
                    $display("[FAIL] %0t wb_rf_wen got %b expected %b",
                             $time, wb_rf_wen, exp.wen);
                    bad++;
                end
                if (exp.wen && wb_rf_wnum !== exp.wnum) begin
                    $display("[FAIL] %0t wb_rf_wnum got %0d expected %0d",
                             $time, wb_rf_wnum, exp.wnum);
                    bad++;
                end
                if (exp.wen && wb_rf_wdata !== exp.wdata) begin
                    $display("[FAIL] %0t wb_rf_wdata got %h expected %h",
                             $time, wb_rf_wdata, exp.wdata);
                    bad++;
                end
                tests++;
                if (bad == 0) passed++;
                errors += bad;
                $display("test %0d pc %h inst %h %s", tests, exp.pc, exp.inst,
                         (bad == 0) ? "ok" : "wrong");
            end
        end
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired at %0t, the pipeline stopped retiring", $time);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        core_isa_pkg::u32_t w;
        int                 gap;
        int                 total;
        inst_valid  = 1'b0;
        inst        = '0;
        pc          = 32'h0000_1000;
        lfsr        = 16'd91;
        squash_next = 1'b0;
        errors      = 0;
        tests       = 0;
        passed      = 0;
        squashed    = 0;
        for (int i = 0; i < core_isa_pkg::REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        fill_table();
        @(posedge rst_n);
        repeat (3) @(negedge clk); // The monitor flags any activity while idle after reset.
        for (int i = 0; i < TABLE_LEN; i++) begin
            issue(stim[i].inst, int'(stim[i].gap));
        end
        for (int i = 0; i < RAND_LEN; i++) begin
            w   = random_inst();
            gap = take_bits(2) % 3;
            issue(w, gap);
        end
        while (trace_q.size() != 0 || redir_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        total = errors + dut.u_chk.fail_count;
        $display("tests %0d passed %0d squashed %0d errors %0d assertion failures %0d",
                 tests, passed, squashed, errors, dut.u_chk.fail_count);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sim/core_chk.sv
module core_chk (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   wb_valid,
    input logic                   wb_rf_wen,
    input core_isa_pkg::reg_idx_t wb_rf_wnum,
    input logic                   redirect_valid
);

    int fail_count = 0;

    wen_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rf_wen |-> wb_valid)
        else begin
            $error("wb_rf_wen high without wb_valid");
            fail_count++;
        end

    no_write_r0: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rf_wen |-> wb_rf_wnum != '0)
        else begin
            $error("register file write aimed at register 0");
            fail_count++;
        end

    redirect_single: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |=> !redirect_valid)
        else begin
            $error("redirect_valid held for two cycles");
            fail_count++;
        end

endmodule

//--- sim/clk_gen.sv
module clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // Released on a falling edge like the other inputs.
    end

endmodule

//--- hw/core_top.sv
module core_top (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   inst_valid,
    input  core_isa_pkg::u32_t     inst,
    input  core_isa_pkg::u32_t     pc,

    output logic                   redirect_valid,
    output core_isa_pkg::u32_t     redirect_pc,

    output logic                   wb_valid,
    output core_isa_pkg::u32_t     wb_pc,
    output core_isa_pkg::u32_t     wb_inst,
    output logic                   wb_rf_wen,
    output core_isa_pkg::reg_idx_t wb_rf_wnum,
    output core_isa_pkg::u32_t     wb_rf_wdata
);

    core_pipe_pkg::decode_execute_pass_t    pass_id;
    core_pipe_pkg::execute_writeback_pass_t pass_ex;
    core_pipe_pkg::fwd_t                    ex_fwd, wb_fwd;

    core_isa_pkg::reg_idx_t ra, rb, rf_wa;
    core_isa_pkg::u32_t     ra_data, rb_data, rf_wd;
    logic                   rf_we;
    logic                   squash;

    reg_file u_reg_file (
        .clk, .rst_n,
        .ra, .rb,
        .ra_data, .rb_data,
        .we(rf_we),
        .wa(rf_wa),
        .wd(rf_wd)
    );

    decode_stage u_decode (
        .clk, .rst_n,
        .inst_valid, .inst, .pc,
        .squash,
        .ra, .rb,
        .ra_data, .rb_data,
        .ex_fwd, .wb_fwd,
        .pass_out(pass_id)
    );

    execute_stage u_execute (
        .clk, .rst_n,
        .pass_in(pass_id),
        .ex_fwd,
        .squash,
        .redirect_valid,
        .redirect_pc,
        .pass_out(pass_ex)
    );

    writeback_stage u_writeback (
        .clk, .rst_n,
        .pass_in(pass_ex),
        .wb_fwd,
        .rf_we, .rf_wa, .rf_wd,
        .wb_valid, .wb_pc, .wb_inst,
        .wb_rf_wen, .wb_rf_wnum, .wb_rf_wdata
    );

endmodule

//--- hw/writeback_stage.sv
module writeback_stage (
    input  logic                                   clk,
    input  logic                                   rst_n,

    input  core_pipe_pkg::execute_writeback_pass_t pass_in,

    output core_pipe_pkg::fwd_t                    wb_fwd,

    output logic                                   rf_we,
    output core_isa_pkg::reg_idx_t                 rf_wa,
    output core_isa_pkg::u32_t                     rf_wd,

    output logic                                   wb_valid,
    output core_isa_pkg::u32_t                     wb_pc,
    output core_isa_pkg::u32_t                     wb_inst,
    output logic                                   wb_rf_wen,
    output core_isa_pkg::reg_idx_t                 wb_rf_wnum,
    output core_isa_pkg::u32_t                     wb_rf_wdata
);

    core_pipe_pkg::execute_writeback_pass_t wb_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_q <= '0;
        end else begin
            wb_q <= pass_in;
        end
    end

    assign rf_we = wb_q.valid && wb_q.wen; // Lands at the end of this cycle.
    assign rf_wa = wb_q.rd;
    assign rf_wd = wb_q.result;

    assign wb_fwd.valid = rf_we;
    assign wb_fwd.rd    = wb_q.rd;
    assign wb_fwd.data  = wb_q.result;

    assign wb_valid    = wb_q.valid;
    assign wb_pc       = wb_q.pc;
    assign wb_inst     = wb_q.inst;
    assign wb_rf_wen   = rf_we;
    assign wb_rf_wnum  = wb_q.rd;
    assign wb_rf_wdata = wb_q.result;

endmodule

//--- hw/execute_stage.sv
module execute_stage (
    input  logic                                  clk,
    input  logic                                  rst_n,

    input  core_pipe_pkg::decode_execute_pass_t   pass_in,

    output core_pipe_pkg::fwd_t                   ex_fwd,

    output logic                                  squash,
    output logic                                  redirect_valid,
    output core_isa_pkg::u32_t                    redirect_pc,

    output core_pipe_pkg::execute_writeback_pass_t pass_out
);

    core_pipe_pkg::decode_execute_pass_t ex_q;
    core_isa_pkg::u32_t                  result;
    logic                                slt;
    logic                                taken;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_q <= '0;
        end else begin
            ex_q <= pass_in;
        end
    end

    assign slt = $signed(ex_q.src_a) < $signed(ex_q.src_b);

    always_comb begin
        case (ex_q.op)
            core_pipe_pkg::ALU_ADD:   result = ex_q.src_a + ex_q.src_b;
            core_pipe_pkg::ALU_SUB:   result = ex_q.src_a - ex_q.src_b;
            core_pipe_pkg::ALU_AND:   result = ex_q.src_a & ex_q.src_b;
            core_pipe_pkg::ALU_OR:    result = ex_q.src_a | ex_q.src_b;
            core_pipe_pkg::ALU_XOR:   result = ex_q.src_a ^ ex_q.src_b;
            core_pipe_pkg::ALU_SLT:   result = {{(core_isa_pkg::WORD_W-1){1'b0}}, slt};
            core_pipe_pkg::ALU_PASSB: result = ex_q.src_b;
            default:                  result = '0;
        endcase
    end

    // Equal for BEQ, unequal for BNE.
    assign taken = ex_q.valid && ex_q.is_branch &&
                   ((ex_q.src_a == ex_q.src_b) ^ ex_q.br_ne);

    assign squash         = taken; // Kills the instruction now in decode.
    assign redirect_valid = taken;
    assign redirect_pc    = ex_q.br_target;

    assign ex_fwd.valid = ex_q.valid && ex_q.wen;
    assign ex_fwd.rd    = ex_q.rd;
    assign ex_fwd.data  = result;

    assign pass_out.valid  = ex_q.valid;
    assign pass_out.pc     = ex_q.pc;
    assign pass_out.inst   = ex_q.inst;
    assign pass_out.rd     = ex_q.rd;
    assign pass_out.wen    = ex_q.wen;
    assign pass_out.result = result;

endmodule

//--- hw/decode_stage.sv
module decode_stage (
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic                               inst_valid,
    input  core_isa_pkg::u32_t                 inst,
    input  core_isa_pkg::u32_t                 pc,
    input  logic                               squash,

    output core_isa_pkg::reg_idx_t             ra,
    output core_isa_pkg::reg_idx_t             rb,
    input  core_isa_pkg::u32_t                 ra_data,
    input  core_isa_pkg::u32_t                 rb_data,

    input  core_pipe_pkg::fwd_t                ex_fwd,
    input  core_pipe_pkg::fwd_t                wb_fwd,

    output core_pipe_pkg::decode_execute_pass_t pass_out
);

    logic                   valid_q;
    core_isa_pkg::u32_t     pc_q;
    core_isa_pkg::u32_t     inst_q;

    core_isa_pkg::opcode_t  opc;
    core_isa_pkg::reg_idx_t rd, rj, rk;
    core_isa_pkg::u32_t     imm_sext, imm_hi;
    core_isa_pkg::u32_t     a_val, b_val;
    logic                   is_branch;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            pc_q   <= pc;
            inst_q <= inst;
        end
    end

    assign opc = inst_q[core_isa_pkg::OPC_LSB +: core_isa_pkg::OPC_W];
    assign rd  = inst_q[core_isa_pkg::RD_LSB +: core_isa_pkg::REG_IDX_W];
    assign rj  = inst_q[core_isa_pkg::RJ_LSB +: core_isa_pkg::REG_IDX_W];
    assign rk  = inst_q[core_isa_pkg::RK_LSB +: core_isa_pkg::REG_IDX_W];

    assign imm_sext = {{(core_isa_pkg::WORD_W - core_isa_pkg::IMM_W){inst_q[core_isa_pkg::IMM_W-1]}},
                       inst_q[core_isa_pkg::IMM_W-1:0]};
    assign imm_hi   = {inst_q[core_isa_pkg::IMM_W-1:0], {core_isa_pkg::IMM_W{1'b0}}};

    assign is_branch = (opc == core_isa_pkg::OP_BEQ) || (opc == core_isa_pkg::OP_BNE);

    assign ra = rj;
    assign rb = is_branch ? rd : rk; // Branches compare rj with rd.

    // Youngest result wins.
    function automatic core_isa_pkg::u32_t fwd_pick(
        input core_isa_pkg::reg_idx_t r,
        input core_isa_pkg::u32_t     rf_data,
        input core_pipe_pkg::fwd_t    ex,
        input core_pipe_pkg::fwd_t    wb
    );
        if (r == '0) return '0;
        if (ex.valid && ex.rd == r) return ex.data;
        if (wb.valid && wb.rd == r) return wb.data;
        return rf_data;
    endfunction

    assign a_val = fwd_pick(ra, ra_data, ex_fwd, wb_fwd);
    assign b_val = fwd_pick(rb, rb_data, ex_fwd, wb_fwd);

    always_comb begin
        pass_out           = '0;
        pass_out.valid     = valid_q && !squash;
        pass_out.pc        = pc_q;
        pass_out.inst      = inst_q;
        pass_out.rd        = rd;
        pass_out.is_branch = is_branch;
        pass_out.br_ne     = (opc == core_isa_pkg::OP_BNE);
        pass_out.src_a     = a_val;
        pass_out.src_b     = b_val;
        pass_out.br_target = pc_q + (imm_sext << 2);
        pass_out.op        = core_pipe_pkg::ALU_ADD;
        case (opc)
            core_isa_pkg::OP_ADD:  pass_out.wen = 1'b1;
            core_isa_pkg::OP_SUB: begin
                pass_out.op  = core_pipe_pkg::ALU_SUB;
                pass_out.wen = 1'b1;
            end
            core_isa_pkg::OP_AND: begin
                pass_out.op  = core_pipe_pkg::ALU_AND;
                pass_out.wen = 1'b1;
            end
            core_isa_pkg::OP_OR: begin
                pass_out.op  = core_pipe_pkg::ALU_OR;
                pass_out.wen = 1'b1;
            end
            core_isa_pkg::OP_XOR: begin
                pass_out.op  = core_pipe_pkg::ALU_XOR;
                pass_out.wen = 1'b1;
            end
            core_isa_pkg::OP_SLT: begin
                pass_out.op  = core_pipe_pkg::ALU_SLT;
                pass_out.wen = 1'b1;
            end
            core_isa_pkg::OP_ADDI: begin
                pass_out.src_b = imm_sext;
                pass_out.wen   = 1'b1;
            end
            core_isa_pkg::OP_LUI: begin
                pass_out.op    = core_pipe_pkg::ALU_PASSB;
                pass_out.src_b = imm_hi;
                pass_out.wen   = 1'b1;
            end
            default: pass_out.wen = 1'b0; // Branches and unknown opcodes write nothing.
        endcase
        if (rd == '0) begin
            pass_out.wen = 1'b0;
        end
    end

endmodule

//--- hw/reg_file.sv
module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,

    input  core_isa_pkg::reg_idx_t ra,
    input  core_isa_pkg::reg_idx_t rb,
    output core_isa_pkg::u32_t     ra_data,
    output core_isa_pkg::u32_t     rb_data,

    input  logic                   we,
    input  core_isa_pkg::reg_idx_t wa,
    input  core_isa_pkg::u32_t     wd
);

    core_isa_pkg::u32_t regs [core_isa_pkg::REG_NUM];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < core_isa_pkg::REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Register 0 reads zero.
    assign ra_data = (ra == '0) ? '0 : regs[ra];
    assign rb_data = (rb == '0) ? '0 : regs[rb];

endmodule

//--- hw/core_pipe_pkg.sv
package core_pipe_pkg;

    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_AND   = 4'd2;
    localparam alu_op_t ALU_OR    = 4'd3;
    localparam alu_op_t ALU_XOR   = 4'd4;
    localparam alu_op_t ALU_SLT   = 4'd5;
    localparam alu_op_t ALU_PASSB = 4'd6; // Passes operand b through for LUI.

    typedef struct packed {
        logic                  valid;
        core_isa_pkg::u32_t    pc;
        core_isa_pkg::u32_t    inst;
        alu_op_t               op;
        core_isa_pkg::reg_idx_t rd;
        logic                  wen;
        logic                  is_branch;
        logic                  br_ne;
        core_isa_pkg::u32_t    src_a;
        core_isa_pkg::u32_t    src_b;
        core_isa_pkg::u32_t    br_target;
    } decode_execute_pass_t;

    typedef struct packed {
        logic                  valid;
        core_isa_pkg::u32_t    pc;
        core_isa_pkg::u32_t    inst;
        core_isa_pkg::reg_idx_t rd;
        logic                  wen;
        core_isa_pkg::u32_t    result;
    } execute_writeback_pass_t;

    typedef struct packed {
        logic                  valid;
        core_isa_pkg::reg_idx_t rd;
        core_isa_pkg::u32_t    data;
    } fwd_t;

endpackage

//--- hw/core_isa_pkg.sv
package core_isa_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_NUM   = 32;
    localparam int REG_IDX_W = 5;
    localparam int OPC_W     = 6;
    localparam int IMM_W     = 16;

    typedef logic [WORD_W-1:0]    u32_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [OPC_W-1:0]     opcode_t;

    // Field positions inside the instruction word.
    localparam int OPC_LSB = 26;
    localparam int RD_LSB  = 21;
    localparam int RJ_LSB  = 16;
    localparam int RK_LSB  = 11;

    localparam opcode_t OP_ADD  = 6'h01;
    localparam opcode_t OP_SUB  = 6'h02;
    localparam opcode_t OP_AND  = 6'h03;
    localparam opcode_t OP_OR   = 6'h04;
    localparam opcode_t OP_XOR  = 6'h05;
    localparam opcode_t OP_SLT  = 6'h06; // Signed compare.
    localparam opcode_t OP_ADDI = 6'h08;
    localparam opcode_t OP_LUI  = 6'h09;
    localparam opcode_t OP_BEQ  = 6'h0c; // Compares rj with rd.
    localparam opcode_t OP_BNE  = 6'h0d;

endpackage
